/* flist.f */
rtl/img_pkg.sv
rtl/uart_pkg.sv
rtl/uart_rx.sv
rtl/pixel_packer.sv
rtl/frame_ram.sv
rtl/frame_reader.sv
rtl/gray_threshold.sv
rtl/tx_fifo.sv
rtl/uart_tx.sv
rtl/uart_img_top.sv
bench/tb_uart_img.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_uart_img
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_uart_img.sv */
`timescale 1ns/1ps

module tb_uart_img;

    localparam int H_RES        = 8;
    localparam int V_RES        = 4;
    localparam int CLKS_PER_BIT = 8;
    localparam int THRESHOLD    = 128;
    localparam int FIFO_DEPTH   = 8;
    localparam int NPIX         = H_RES * V_RES;
    localparam int BYTE_TIMEOUT = 40000;             // cycles
    localparam int QUIET_CYCLES = CLKS_PER_BIT * 30;

    logic clk;
    logic reset;
    logic i_rx;
    logic o_tx;

    uart_pkg::byte_t got_q [$];   // decoded from o_tx
    uart_pkg::byte_t exp_q [$];
    img_pkg::rgb_t   frame_px [0:NPIX-1];
    logic [31:0]     rng;
    logic            abort;
    int              rx_count;
    int              errors;
    int              checks;
    int              tests_run;
    int              tests_failed;
    int              err_base;

    uart_img_top #(
        .H_RES(H_RES), .V_RES(V_RES), .CLKS_PER_BIT(CLKS_PER_BIT),
        .THRESHOLD(THRESHOLD), .FIFO_DEPTH(FIFO_DEPTH)
    ) u_uart_img_top (
        .clk(clk), .reset(reset), .i_rx(i_rx), .o_tx(o_tx)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected output byte for one pixel
    function automatic uart_pkg::byte_t luma_ref(input img_pkg::rgb_t p);
        int unsigned sum;
        sum = p.r * img_pkg::LUMA_R + p.g * img_pkg::LUMA_G + p.b * img_pkg::LUMA_B;
        return ((sum >> 8) >= THRESHOLD) ? 8'hff : 8'h00;
    endfunction

    task automatic check_byte(input string name, input uart_pkg::byte_t got,
                              input uart_pkg::byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at time %0t: %s got 8'h%02h expected 8'h%02h", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at time %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic drive_bit(input logic b);
        @(posedge clk);
        i_rx <= b;
        repeat (CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic send_byte(input uart_pkg::byte_t data, input logic stop);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);                  // lsb first
        end
        drive_bit(stop);
    endtask

    // bad_pix below zero sends a clean frame
    task automatic stream_pixels(input int bad_pix);
        for (int i = 0; i < NPIX; i++) begin
            send_byte(frame_px[i].r, 1'b1);
            if (i == bad_pix) begin
                send_byte(frame_px[i].g ^ 8'h5a, 1'b0);  // framing error
                drive_bit(1'b1);                          // idle before the resend
            end
            send_byte(frame_px[i].g, 1'b1);
            send_byte(frame_px[i].b, 1'b1);
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < NPIX; i++) begin
            rng = xorshift32(rng);
            frame_px[i] = '{r: rng[7:0], g: rng[15:8], b: rng[23:16]};
        end
    endtask

    task automatic queue_reference(input int first);
        for (int i = first; i < NPIX; i++) begin
            exp_q.push_back(luma_ref(frame_px[i]));
        end
    endtask

    task automatic wait_bytes(input int target);
        int cycles;
        cycles = 0;
        while (rx_count < target && cycles < BYTE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rx_count < target) begin
            $display("timeout after %0d cycles: waiting for %0d output bytes, %0d arrived",
                     cycles, target, rx_count);
            abort = 1'b1;
        end
    endtask

    // nothing more may follow the frame
    task automatic drain_frame(input int target);
        wait_bytes(target);
        if (!abort) begin
            repeat (QUIET_CYCLES) @(posedge clk);
            checks++;
            if (rx_count != target) begin
                errors++;
                $display("Fail at time %0t: output byte count got %0d expected %0d",
                         $time, rx_count, target);
            end
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_base && !abort) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_base);
        end
        err_base = errors;
    endtask

    task automatic idle_after_reset();
        for (int i = 0; i < 200; i++) begin
            @(negedge clk);
            if (o_tx !== 1'b1) begin
                check_line("o_tx", o_tx, 1'b1);
                break;
            end
        end
        end_test("idle after reset");
    endtask

    task automatic run_frame(input string name, input int bad_pix);
        int target;
        target = rx_count + NPIX;
        fill_random();
        queue_reference(0);
        stream_pixels(bad_pix);
        drain_frame(target);
        end_test(name);
    endtask

    task automatic threshold_edges();
        int target;
        target = rx_count + NPIX;
        frame_px[0] = '{r: 8'd128, g: 8'd128, b: 8'd128};  // luma at threshold
        frame_px[1] = '{r: 8'd127, g: 8'd127, b: 8'd127};
        frame_px[2] = '{r: 8'h00, g: 8'h00, b: 8'h00};
        frame_px[3] = '{r: 8'hff, g: 8'hff, b: 8'hff};
        for (int i = 4; i < NPIX; i++) begin
            frame_px[i] = '{r: 8'(i * 8), g: 8'(i * 8), b: 8'(i * 8)};
        end
        exp_q.push_back(8'hff);
        exp_q.push_back(8'h00);
        exp_q.push_back(8'h00);
        exp_q.push_back(8'hff);
        queue_reference(4);
        stream_pixels(-1);
        drain_frame(target);
        end_test("threshold edges");
    endtask

    task automatic back_to_back_frames();
        int target;
        target = rx_count + 2 * NPIX;
        fill_random();
        queue_reference(0);
        stream_pixels(-1);
        fill_random();                 // second frame follows with no gap
        queue_reference(0);
        stream_pixels(-1);
        drain_frame(target);
        end_test("back-pressure, two frames at full rate");
    endtask

    always begin : tx_monitor
        uart_pkg::byte_t data;
        @(negedge clk);
        if (o_tx === 1'b0) begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);   // middle of start bit
            if (o_tx !== 1'b0) begin
                errors++;
                $display("start bit on o_tx at time %0t was shorter than half a bit", $time);
            end else begin
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    data[i] = o_tx;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                check_line("o_tx stop bit", o_tx, 1'b1);
                got_q.push_back(data);
                rx_count++;
            end
        end
    end

    always @(negedge clk) begin : compare_bytes
        uart_pkg::byte_t got;
        uart_pkg::byte_t exp;
        if (got_q.size() != 0) begin
            got = got_q.pop_front();
            if (exp_q.size() == 0) begin
                errors++;
                $display("output byte 8'h%02h arrived with no expected value", got);
            end else begin
                exp = exp_q.pop_front();
                check_byte("o_tx byte", got, exp);
            end
        end
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        i_rx         = 1'b1;
        rng          = 32'hba51_7bad;
        abort        = 1'b0;
        rx_count     = 0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_base     = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        idle_after_reset();
        if (!abort) run_frame("random frame", -1);
        if (!abort) threshold_edges();
        if (!abort) back_to_back_frames();
        if (!abort) run_frame("second frame after idle", -1);
        if (!abort) run_frame("dropped byte with bad stop bit", 5);

        if (abort) $display("run stopped early after a timeout");
        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0 && !abort) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* rtl/uart_img_top.sv */
`timescale 1ns/1ps

module uart_img_top #(
    parameter int H_RES        = 160,
    parameter int V_RES        = 120,
    parameter int CLKS_PER_BIT = 868,
    parameter int THRESHOLD    = 128,
    parameter int FIFO_DEPTH   = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic i_rx,
    output logic o_tx
);

    localparam int ADDR_W = $clog2(H_RES * V_RES);

    uart_pkg::rx_beat_t rx_beat;
    logic               we;
    logic [ADDR_W-1:0]  waddr;
    img_pkg::rgb_t      wdata;
    logic               frame_done;
    logic               frame_ready;
    logic [ADDR_W-1:0]  raddr;
    img_pkg::rgb_t      rdata;
    img_pkg::pix_beat_t pix;
    img_pkg::bin_beat_t bin;
    logic               stall;
    logic               not_empty;
    uart_pkg::byte_t    head;
    logic               pop;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
        .clk(clk), .reset(reset), .i_rx(i_rx), .o_rx(rx_beat)
    );

    pixel_packer #(.H_RES(H_RES), .V_RES(V_RES)) u_pixel_packer (
        .clk(clk), .reset(reset), .i_rx(rx_beat), .o_we(we),
        .o_waddr(waddr), .o_wdata(wdata), .o_frame_done(frame_done)
    );

    frame_ram #(.H_RES(H_RES), .V_RES(V_RES)) u_frame_ram (
        .clk(clk), .i_we(we), .i_waddr(waddr), .i_wdata(wdata),
        .i_frame_done(frame_done), .i_raddr(raddr), .o_rdata(rdata),
        .o_frame_ready(frame_ready)
    );

    frame_reader #(.H_RES(H_RES), .V_RES(V_RES)) u_frame_reader (
        .clk(clk), .reset(reset), .i_frame_ready(frame_ready), .i_stall(stall),
        .o_raddr(raddr), .i_rdata(rdata), .o_pix(pix)
    );

    gray_threshold #(.THRESHOLD(THRESHOLD)) u_gray_threshold (
        .clk(clk), .reset(reset), .i_pix(pix), .o_bin(bin)
    );

    tx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .clk(clk), .reset(reset), .i_push(bin), .o_stall(stall),
        .o_not_empty(not_empty), .o_head(head), .i_pop(pop)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
        .clk(clk), .reset(reset), .i_not_empty(not_empty), .i_head(head),
        .o_pop(pop), .o_tx(o_tx)
    );

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            i_not_empty,
    input  uart_pkg::byte_t i_head,
    output logic            o_pop,
    output logic            o_tx
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    logic             busy;
    logic             bit_end;
    logic             last_tick;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic [9:0]       shift_q;   // stop, data, start

    assign bit_end   = busy && (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign last_tick = bit_end && (bit_cnt == 4'd9);
    assign o_pop     = i_not_empty && (!busy || last_tick);  // reload at end of stop
    assign o_tx      = shift_q[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
            shift_q <= '1;
        end else if (o_pop) begin
            busy    <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
            shift_q <= {1'b1, i_head, 1'b0};
        end else if (last_tick) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
            shift_q <= '1;
        end else if (bit_end) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            shift_q <= {1'b1, shift_q[9:1]};
        end else if (busy) begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

endmodule

/* rtl/tx_fifo.sv */
`timescale 1ns/1ps

module tx_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  img_pkg::bin_beat_t i_push,
    output logic               o_stall,
    output logic               o_not_empty,
    output uart_pkg::byte_t    o_head,
    input  logic               i_pop
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    uart_pkg::byte_t  mem [0:FIFO_DEPTH-1];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign full        = (count == CNT_W'(FIFO_DEPTH));
    assign wr_en       = i_push.de && !full;
    assign rd_en       = i_pop && o_not_empty;
    assign o_not_empty = (count != '0);
    assign o_head      = mem[rd_ptr];
    assign o_stall     = (count >= CNT_W'(FIFO_DEPTH - 4));  // room for beats in flight

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= i_push.value;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        i_push.de |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        i_pop |-> o_not_empty);

endmodule

/* rtl/gray_threshold.sv */
`timescale 1ns/1ps

module gray_threshold #(
    parameter int THRESHOLD = 128
) (
    input  logic               clk,
    input  logic               reset,
    input  img_pkg::pix_beat_t i_pix,
    output img_pkg::bin_beat_t o_bin
);

    logic        de_s1;
    logic        de_s2;
    logic [15:0] sum_s1;    // weighted sum, luma in the top byte
    logic [7:0]  luma;
    logic [7:0]  value_s2;

    assign luma = sum_s1[15:8];

    always_ff @(posedge clk) begin
        if (reset) begin
            de_s1 <= 1'b0;
            de_s2 <= 1'b0;
        end else begin
            de_s1 <= i_pix.de;
            de_s2 <= de_s1;
        end
    end

    always_ff @(posedge clk) begin
        sum_s1 <= 16'(i_pix.px.r * img_pkg::LUMA_R
                    + i_pix.px.g * img_pkg::LUMA_G
                    + i_pix.px.b * img_pkg::LUMA_B);
        value_s2 <= (luma >= 8'(THRESHOLD)) ? 8'hff : 8'h00;
    end

    always_comb begin
        o_bin.de    = de_s2;
        o_bin.value = value_s2;
    end

endmodule

/* rtl/frame_reader.sv */
`timescale 1ns/1ps

module frame_reader #(
    parameter int H_RES = 8,
    parameter int V_RES = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             i_frame_ready,
    input  logic                             i_stall,
    output logic [$clog2(H_RES * V_RES)-1:0] o_raddr,
    input  img_pkg::rgb_t                    i_rdata,
    output img_pkg::pix_beat_t               o_pix
);

    localparam int NPIX   = H_RES * V_RES;
    localparam int ADDR_W = $clog2(NPIX);
    localparam int X_W    = $clog2(H_RES + 1);
    localparam int Y_W    = $clog2(V_RES + 1);

    logic           reading;
    logic           issue;
    logic           issue_d;   // lines up with ram output
    logic           last_px;
    logic [X_W-1:0] x_cnt;
    logic [Y_W-1:0] y_cnt;

    assign issue   = reading && !i_stall;
    assign last_px = (x_cnt == X_W'(H_RES - 1)) && (y_cnt == Y_W'(V_RES - 1));
    assign o_raddr = ADDR_W'(y_cnt * H_RES + x_cnt);

    always_ff @(posedge clk) begin
        if (reset) begin
            reading <= 1'b0;
        end else if (!reading) begin
            reading <= i_frame_ready;   // ready during a scan is ignored
        end else if (issue && last_px) begin
            reading <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !reading) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (issue) begin
            if (x_cnt == X_W'(H_RES - 1)) begin
                x_cnt <= '0;
                y_cnt <= (y_cnt == Y_W'(V_RES - 1)) ? '0 : y_cnt + 1'b1;
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_d <= 1'b0;
        end else begin
            issue_d <= issue;
        end
    end

    always_comb begin
        o_pix.de = issue_d;
        o_pix.px = i_rdata;
    end

    a_stall_holds: assert property (@(posedge clk) disable iff (reset)
        (reading && i_stall) |=> ($stable(o_raddr) && !o_pix.de));

endmodule

/* rtl/frame_ram.sv */
`timescale 1ns/1ps

module frame_ram #(
    parameter int H_RES = 8,
    parameter int V_RES = 4
) (
    input  logic                             clk,
    input  logic                             i_we,
    input  logic [$clog2(H_RES * V_RES)-1:0] i_waddr,
    input  img_pkg::rgb_t                    i_wdata,
    input  logic                             i_frame_done,
    input  logic [$clog2(H_RES * V_RES)-1:0] i_raddr,
    output img_pkg::rgb_t                    o_rdata,
    output logic                             o_frame_ready
);

    localparam int NPIX = H_RES * V_RES;

    img_pkg::rgb_t mem [0:NPIX-1];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        o_rdata <= mem[i_raddr];
    end

    // last write lands before the reader sees ready
    always_ff @(posedge clk) begin
        o_frame_ready <= i_frame_done;
    end

endmodule

/* rtl/pixel_packer.sv */
`timescale 1ns/1ps

module pixel_packer #(
    parameter int H_RES = 8,
    parameter int V_RES = 4
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  uart_pkg::rx_beat_t                   i_rx,
    output logic                                 o_we,
    output logic [$clog2(H_RES * V_RES)-1:0]     o_waddr,
    output img_pkg::rgb_t                        o_wdata,
    output logic                                 o_frame_done
);

    localparam int NPIX   = H_RES * V_RES;
    localparam int ADDR_W = $clog2(NPIX);
    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(NPIX - 1);

    logic [1:0]        phase;     // 0 r, 1 g, 2 b
    logic [ADDR_W-1:0] pix_cnt;
    logic              last_pix;
    uart_pkg::byte_t   r_hold;
    uart_pkg::byte_t   g_hold;

    assign last_pix = (pix_cnt == LAST_ADDR);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase        <= '0;
            pix_cnt      <= '0;
            o_we         <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            o_we         <= 1'b0;
            o_frame_done <= 1'b0;
            if (i_rx.valid) begin
                if (phase == 2'd2) begin
                    phase        <= '0;
                    o_we         <= 1'b1;
                    o_frame_done <= last_pix;
                    pix_cnt      <= last_pix ? '0 : pix_cnt + 1'b1;
                end else begin
                    phase <= phase + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rx.valid) begin
            case (phase)
                2'd0: r_hold <= i_rx.data;
                2'd1: g_hold <= i_rx.data;
                2'd2: begin
                    o_waddr <= pix_cnt;
                    o_wdata <= '{r: r_hold, g: g_hold, b: i_rx.data};
                end
                default: ;
            endcase
        end
    end

    a_done_on_last: assert property (@(posedge clk) disable iff (reset)
        o_frame_done == (o_we && (o_waddr == LAST_ADDR)));

endmodule

/* rtl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               i_rx,
    output uart_pkg::rx_beat_t o_rx
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    logic             busy;
    logic             sample;
    logic             valid_q;
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;   // 0 start, 1..8 data, 9 stop
    uart_pkg::byte_t  shift_q;

    assign sample = busy && (clk_cnt == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (!busy) begin
                if (rx_prev && !rx_sync) begin  // start edge
                    busy    <= 1'b1;
                    clk_cnt <= CNT_W'(CLKS_PER_BIT / 2 - 1);
                    bit_cnt <= '0;
                end
            end else if (!sample) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= CNT_W'(CLKS_PER_BIT - 1);
                if (bit_cnt == 4'd0 && rx_sync) begin
                    busy <= 1'b0;               // glitch, not a start bit
                end else if (bit_cnt == 4'd9) begin
                    busy    <= 1'b0;
                    bit_cnt <= '0;
                    valid_q <= rx_sync;         // bad stop bit drops the byte
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            shift_q <= {rx_sync, shift_q[7:1]};  // lsb first
        end
    end

    always_comb begin
        o_rx.valid = valid_q;
        o_rx.data  = shift_q;
    end

    a_bit_cnt_range: assert property (@(posedge clk) disable iff (reset)
        bit_cnt <= 4'd9);

endmodule

/* rtl/uart_pkg.sv */
package uart_pkg;

    typedef logic [7:0] byte_t;

    // received byte, valid is a one-cycle strobe
    typedef struct packed {
        logic  valid;
        byte_t data;
    } rx_beat_t;

endpackage

/* rtl/img_pkg.sv */
package img_pkg;

    // one pixel as it travels from the receive side to the buffer
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic de;     // pixel enable
        rgb_t px;
    } pix_beat_t;

    typedef struct packed {
        logic       de;
        logic [7:0] value;  // 8'hff or 8'h00
    } bin_beat_t;

    // luma weights, sum is 256
    localparam int unsigned LUMA_R = 77;
    localparam int unsigned LUMA_G = 150;
    localparam int unsigned LUMA_B = 29;

endpackage
